// ==== src/rv_isa_pkg.sv ====
// RV64I encodings and constants shared by the decoder, the core and the testbench
package rv_isa_pkg;

  // Data path width
  localparam int XLEN = 64;

  // The PC comes out of reset here, the usual start of RAM
  localparam logic [XLEN-1:0] RESET_PC = 64'h8000_0000;

  // Major opcodes, inst[6:0]
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // Minor opcodes, inst[14:12]
  localparam logic [2:0] F3_ADDI = 3'b000;
  localparam logic [2:0] F3_JALR = 3'b000;
  localparam logic [2:0] F3_SD   = 3'b011;

  // Ecall and ebreak share this one
  localparam logic [2:0] F3_PRIV = 3'b000;

  // Immediate layouts
  // IMM_NONE covers R-type and anything the decoder does not know
  typedef enum logic [2:0] {
    IMM_I    = 3'b000,
    IMM_U    = 3'b001,
    IMM_S    = 3'b010,
    IMM_B    = 3'b011,
    IMM_J    = 3'b100,
    IMM_NONE = 3'b111
  } imm_fmt_e;

endpackage

// ==== src/core_ctrl_pkg.sv ====
// Control encodings passed from the decoder to the execute stage and the core top level
package core_ctrl_pkg;

  // ALU operation
  typedef enum logic [3:0] {
    ALU_ADD     = 4'b0000,
    ALU_COPY_B  = 4'b0011,
    ALU_EBREAK  = 4'b1110,
    ALU_INVALID = 4'b1111
  } alu_op_e;

  // ALU operand A source
  typedef enum logic {
    ASRC_RS1 = 1'b0,
    ASRC_PC  = 1'b1
  } asrc_e;

  // ALU operand B source
  // BSRC_FOUR builds the link address for jal and jalr
  typedef enum logic [1:0] {
    BSRC_RS2  = 2'b00,
    BSRC_IMM  = 2'b01,
    BSRC_FOUR = 2'b10
  } bsrc_e;

  // Everything the rest of the core needs to know about one instruction
  typedef struct packed {
    logic                            reg_wen;
    logic                            mem_wen;
    logic                            is_jal;
    logic                            is_jalr;
    asrc_e                           asrc;
    bsrc_e                           bsrc;
    alu_op_e                         alu_op;
    logic [rv_isa_pkg::XLEN-1:0]     imm;
  } ctrl_t;

endpackage

// ==== src/mux_key.sv ====
// Keyed lookup table mux, returns the payload whose key matches or a default when none does
`timescale 1ns/1ps

module mux_key #(
  parameter int  NR_KEY  = 2,
  parameter int  KEY_LEN = 1,
  parameter type DATA_T  = logic [7:0]
) (
  input  logic [KEY_LEN-1:0]                            i_key,
  input  logic [NR_KEY*(KEY_LEN+$bits(DATA_T))-1:0]     i_lut,
  input  DATA_T                                         i_default,
  output DATA_T                                         o_out
);

  localparam int DATA_LEN = $bits(DATA_T);
  localparam int PAIR_LEN = KEY_LEN + DATA_LEN;

  // Each entry is {key, payload}, the first listed entry sits at the top of i_lut
  always_comb begin
    logic [PAIR_LEN-1:0] pair;
    logic [KEY_LEN-1:0]  pair_key;
    logic [DATA_LEN-1:0] pair_data;

    o_out = i_default;
    for (int i = 0; i < NR_KEY; i++) begin
      pair      = i_lut[i*PAIR_LEN +: PAIR_LEN];
      pair_key  = pair[PAIR_LEN-1 -: KEY_LEN];
      pair_data = pair[DATA_LEN-1:0];
      if (pair_key == i_key) begin
        o_out = DATA_T'(pair_data);
      end
    end
  end

endmodule

// ==== src/idu.sv ====
// Instruction decoder, splits out register indices and builds the immediate and control bundle
`timescale 1ns/1ps

module idu
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;
(
  input  logic [31:0] i_inst,
  output logic [4:0]  o_rs1,
  output logic [4:0]  o_rs2,
  output logic [4:0]  o_rd,
  output ctrl_t       o_ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign o_rs1  = i_inst[19:15];
  assign o_rs2  = i_inst[24:20];
  assign o_rd   = i_inst[11:7];

  // Sign-extended immediates for every layout
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_j;

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  logic inst_lui;
  logic inst_auipc;
  logic inst_jal;
  logic inst_jalr;
  logic inst_addi;
  logic inst_sd;
  logic inst_ebreak;

  assign inst_lui    = (opcode == OP_LUI);
  assign inst_auipc  = (opcode == OP_AUIPC);
  assign inst_jal    = (opcode == OP_JAL);
  assign inst_jalr   = (opcode == OP_JALR) && (funct3 == F3_JALR);
  assign inst_addi   = (opcode == OP_IMM) && (funct3 == F3_ADDI);
  assign inst_sd     = (opcode == OP_STORE) && (funct3 == F3_SD);
  assign inst_ebreak = (opcode == OP_SYSTEM) && (funct3 == F3_PRIV);

  logic type_i;
  logic type_u;
  logic type_s;
  logic type_j;

  assign type_i = inst_addi | inst_jalr | inst_ebreak;
  assign type_u = inst_lui | inst_auipc;
  assign type_s = inst_sd;
  assign type_j = inst_jal;

  // Format from the one-hot type vector, no branches yet so B never shows up here
  imm_fmt_e imm_fmt;

  mux_key #(.NR_KEY(4), .KEY_LEN(4), .DATA_T(imm_fmt_e)) u_fmt_mux (
    .i_key     ({type_i, type_u, type_s, type_j}),
    .i_lut     ({4'b1000, IMM_I,
                 4'b0100, IMM_U,
                 4'b0010, IMM_S,
                 4'b0001, IMM_J}),
    .i_default (IMM_NONE),
    .o_out     (imm_fmt)
  );

  logic [XLEN-1:0] imm;

  mux_key #(.NR_KEY(4), .KEY_LEN(3), .DATA_T(logic [XLEN-1:0])) u_imm_mux (
    .i_key     (imm_fmt),
    .i_lut     ({IMM_I, imm_i,
                 IMM_U, imm_u,
                 IMM_S, imm_s,
                 IMM_J, imm_j}),
    .i_default ('0),
    .o_out     (imm)
  );

  logic alu_copy_b;
  logic alu_add;

  assign alu_copy_b = inst_lui;
  // Jalr adds too, its link value is PC plus four like jal
  assign alu_add    = inst_auipc | inst_jal | inst_jalr | inst_addi | inst_sd;

  alu_op_e alu_op;

  mux_key #(.NR_KEY(3), .KEY_LEN(3), .DATA_T(alu_op_e)) u_alu_mux (
    .i_key     ({alu_copy_b, alu_add, inst_ebreak}),
    .i_lut     ({3'b100, ALU_COPY_B,
                 3'b010, ALU_ADD,
                 3'b001, ALU_EBREAK}),
    .i_default (ALU_INVALID),
    .o_out     (alu_op)
  );

  always_comb begin
    o_ctrl         = '0;
    o_ctrl.reg_wen = (type_i | type_u | type_j) & ~inst_ebreak;
    o_ctrl.mem_wen = inst_sd;
    o_ctrl.is_jal  = inst_jal;
    o_ctrl.is_jalr = inst_jalr;
    o_ctrl.asrc    = (inst_jal | inst_jalr | inst_auipc) ? ASRC_PC : ASRC_RS1;
    if (inst_jal || inst_jalr) begin
      o_ctrl.bsrc = BSRC_FOUR;
    end else if (type_i || type_u || type_s) begin
      o_ctrl.bsrc = BSRC_IMM;
    end else begin
      o_ctrl.bsrc = BSRC_RS2;
    end
    o_ctrl.alu_op  = alu_op;
    o_ctrl.imm     = imm;
  end

endmodule

// ==== src/regfile.sv ====
// Integer register file with two asynchronous read ports and one clocked write port
`timescale 1ns/1ps

module regfile
  import rv_isa_pkg::*;
(
  input  logic            i_clk,
  input  logic            i_wen,
  input  logic [4:0]      i_waddr,
  input  logic [XLEN-1:0] i_wdata,
  input  logic [4:0]      i_raddr_a,
  input  logic [4:0]      i_raddr_b,
  output logic [XLEN-1:0] o_rdata_a,
  output logic [XLEN-1:0] o_rdata_b
);

  logic [XLEN-1:0] regs [32];

  always_ff @(posedge i_clk) begin
    if (i_wen && (i_waddr != 5'd0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // x0 is never written, so force its read value rather than trusting the array
  assign o_rdata_a = (i_raddr_a == 5'd0) ? '0 : regs[i_raddr_a];
  assign o_rdata_b = (i_raddr_b == 5'd0) ? '0 : regs[i_raddr_b];

endmodule

// ==== src/exu.sv ====
// Execute stage, picks ALU operands, computes the result and the address of the next instruction
`timescale 1ns/1ps

module exu
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;
(
  input  ctrl_t           i_ctrl,
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_rs1_data,
  input  logic [XLEN-1:0] i_rs2_data,
  output logic [XLEN-1:0] o_result,
  output logic [XLEN-1:0] o_next_pc
);

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] jalr_target;

  assign op_a = (i_ctrl.asrc == ASRC_PC) ? i_pc : i_rs1_data;

  always_comb begin
    case (i_ctrl.bsrc)
      BSRC_RS2:  op_b = i_rs2_data;
      BSRC_IMM:  op_b = i_ctrl.imm;
      BSRC_FOUR: op_b = 64'd4;
      default:   op_b = '0;
    endcase
  end

  // Ebreak and unknown instructions produce nothing, the core never writes it
  always_comb begin
    case (i_ctrl.alu_op)
      ALU_ADD:    o_result = op_a + op_b;
      ALU_COPY_B: o_result = op_b;
      default:    o_result = '0;
    endcase
  end

  assign jalr_target = i_rs1_data + i_ctrl.imm;

  always_comb begin
    if (i_ctrl.is_jal) begin
      o_next_pc = i_pc + i_ctrl.imm;
    end else if (i_ctrl.is_jalr) begin
      o_next_pc = {jalr_target[XLEN-1:1], 1'b0};
    end else begin
      o_next_pc = i_pc + 64'd4;
    end
  end

endmodule

// ==== src/rv64_core.sv ====
// Single-cycle RV64I core top level with PC, halt state and a write-only store port
`timescale 1ns/1ps

module rv64_core
  import rv_isa_pkg::*;
  import core_ctrl_pkg::*;
(
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic [31:0]     i_inst,
  output logic [XLEN-1:0] o_pc,
  output logic            o_mem_wen,
  output logic [XLEN-1:0] o_mem_addr,
  output logic [XLEN-1:0] o_mem_wdata,
  output logic            o_halt
);

  logic [XLEN-1:0] pc;
  logic            halt;

  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [4:0]      rd;
  ctrl_t           ctrl;

  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] result;
  logic [XLEN-1:0] next_pc;

  logic            active;
  logic            is_ebreak;

  idu u_idu (
    .i_inst (i_inst),
    .o_rs1  (rs1),
    .o_rs2  (rs2),
    .o_rd   (rd),
    .o_ctrl (ctrl)
  );

  // Nothing retires once halted or while held in reset
  assign active    = ~halt & ~i_rst;
  assign is_ebreak = (ctrl.alu_op == ALU_EBREAK);

  regfile u_regfile (
    .i_clk     (i_clk),
    .i_wen     (ctrl.reg_wen & active),
    .i_waddr   (rd),
    .i_wdata   (result),
    .i_raddr_a (rs1),
    .i_raddr_b (rs2),
    .o_rdata_a (rs1_data),
    .o_rdata_b (rs2_data)
  );

  exu u_exu (
    .i_ctrl     (ctrl),
    .i_pc       (pc),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_result   (result),
    .o_next_pc  (next_pc)
  );

  // The PC parks on the ebreak so the halted state points at it
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc   <= RESET_PC;
      halt <= 1'b0;
    end else if (!halt) begin
      if (is_ebreak) begin
        halt <= 1'b1;
      end else begin
        pc <= next_pc;
      end
    end
  end

  assign o_pc        = pc;
  assign o_halt      = halt;
  assign o_mem_wen   = ctrl.mem_wen & active;
  assign o_mem_addr  = result;
  assign o_mem_wdata = rs2_data;

endmodule

// ==== test/tb_core.sv ====
// Directed testbench for the single-cycle core, run as the top module with the file list
`timescale 1ns/1ps

module tb_core
  import rv_isa_pkg::*;
();

  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] data;
  } store_t;

  logic            clk = 1'b0;
  logic            rst = 1'b1;
  logic [31:0]     inst;
  logic [XLEN-1:0] pc;
  logic            mem_wen;
  logic [XLEN-1:0] mem_addr;
  logic [XLEN-1:0] mem_wdata;
  logic            halt;

  logic [31:0]     imem [256];
  logic [31:0]     prog [$];
  store_t          stores [$];
  store_t          exp_stores [$];
  logic [XLEN-1:0] fetch_offset;
  logic [31:0]     seed = 32'hb5f2_1d75;

  int test_errors  = 0;
  int total_errors = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  bit timed_out    = 1'b0;

  rv64_core UUT (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_inst      (inst),
    .o_pc        (pc),
    .o_mem_wen   (mem_wen),
    .o_mem_addr  (mem_addr),
    .o_mem_wdata (mem_wdata),
    .o_halt      (halt)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] ebreak_inst();
    return {12'h001, 5'd0, F3_PRIV, 5'd0, OP_SYSTEM};
  endfunction

  function automatic logic [31:0] lui_inst(logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, OP_LUI};
  endfunction

  function automatic logic [31:0] auipc_inst(logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, OP_AUIPC};
  endfunction

  function automatic logic [31:0] addi_inst(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, F3_ADDI, rd, OP_IMM};
  endfunction

  function automatic logic [31:0] jalr_inst(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, F3_JALR, rd, OP_JALR};
  endfunction

  function automatic logic [31:0] jal_inst(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
  endfunction

  function automatic logic [31:0] sd_inst(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] off);
    return {off[11:5], rs2, rs1, F3_SD, off[4:0], OP_STORE};
  endfunction

  // Value of a raw immediate field once the ISA has placed and sign-extended it
  function automatic logic [XLEN-1:0] imm_value(imm_fmt_e fmt, logic [31:0] raw);
    case (fmt)
      IMM_I, IMM_S: return {{52{raw[11]}}, raw[11:0]};
      IMM_U:        return {{32{raw[19]}}, raw[19:0], 12'b0};
      IMM_J:        return {{43{raw[20]}}, raw[20:0]};
      default:      return '0;
    endcase
  endfunction

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Word-aligned fetch inside the loaded window, ebreak everywhere else
  assign fetch_offset = pc - RESET_PC;

  always_comb begin
    if (fetch_offset < 64'd1024 && fetch_offset[1:0] == 2'b00) begin
      inst = imem[fetch_offset[9:2]];
    end else begin
      inst = ebreak_inst();
    end
  end

  // Store strobes are sampled mid-cycle where the combinational outputs have settled
  always @(negedge clk) begin
    if (mem_wen === 1'b1) begin
      stores.push_back({mem_addr, mem_wdata});
    end
  end

  task automatic mismatch(string what, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
    $display("FAIL at time %0t: %s, got %h, expected %h", $time, what, got, exp);
    test_errors++;
  endtask

  task automatic load_program();
    for (int i = 0; i < 256; i++) begin
      imem[8'(i)] = (i < prog.size()) ? prog[i] : ebreak_inst();
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    for (int i = 0; i < 16; i++) begin
      @(negedge clk);
      if (i > 0) begin
        if (pc !== RESET_PC) mismatch("pc during reset", pc, RESET_PC);
        if (mem_wen !== 1'b0) mismatch("mem_wen during reset", {63'd0, mem_wen}, 64'd0);
        if (halt !== 1'b0) mismatch("halt during reset", {63'd0, halt}, 64'd0);
      end
    end
    @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic run_program();
    int cycles;
    cycles = 0;
    load_program();
    stores.delete();
    apply_reset();
    while (halt !== 1'b1 && cycles < 200) begin
      @(negedge clk);
      cycles++;
    end
    if (halt !== 1'b1) begin
      $display("Timeout: the core did not reach ebreak within 200 cycles");
      test_errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic check_stores(string name);
    if (stores.size() != exp_stores.size()) begin
      mismatch({name, " store count"}, 64'(stores.size()), 64'(exp_stores.size()));
    end else begin
      foreach (exp_stores[i]) begin
        if (stores[i].addr !== exp_stores[i].addr)
          mismatch($sformatf("%s store %0d address", name, i), stores[i].addr,
                   exp_stores[i].addr);
        if (stores[i].data !== exp_stores[i].data)
          mismatch($sformatf("%s store %0d data", name, i), stores[i].data,
                   exp_stores[i].data);
      end
    end
  endtask

  task automatic finish_test(string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("Test %s passed", name);
    end else begin
      $display("Test %s failed with %0d errors", name, test_errors);
      tests_failed++;
    end
    total_errors += test_errors;
    test_errors = 0;
  endtask

  task automatic reset_and_halt();
    prog.delete();
    prog.push_back(ebreak_inst());
    load_program();
    apply_reset();
    @(negedge clk);
    if (pc !== RESET_PC) mismatch("pc after reset", pc, RESET_PC);
    if (halt !== 1'b0) mismatch("halt after reset", {63'd0, halt}, 64'd0);
    if (mem_wen !== 1'b0) mismatch("mem_wen after reset", {63'd0, mem_wen}, 64'd0);
    @(negedge clk);
    if (halt !== 1'b1) mismatch("halt one cycle after ebreak", {63'd0, halt}, 64'd1);
    if (pc !== RESET_PC) mismatch("pc at ebreak", pc, RESET_PC);
    finish_test("reset_and_halt");
  endtask

  task automatic upper_immediates();
    prog = '{lui_inst(5'd1, 20'h12345), addi_inst(5'd1, 5'd1, 12'h678),
             lui_inst(5'd2, 20'hfffff), addi_inst(5'd2, 5'd2, 12'hfff),
             auipc_inst(5'd3, 20'h00010), addi_inst(5'd4, 5'd0, 12'h800),
             lui_inst(5'd5, 20'h80000), addi_inst(5'd10, 5'd0, 12'h100),
             sd_inst(5'd1, 5'd10, 12'h000), sd_inst(5'd2, 5'd10, 12'h008),
             sd_inst(5'd3, 5'd10, 12'h010), sd_inst(5'd4, 5'd10, 12'h018),
             sd_inst(5'd5, 5'd10, 12'h020), ebreak_inst()};
    // The auipc sits at word 4
    exp_stores = '{{64'h100, imm_value(IMM_U, 32'h12345) + imm_value(IMM_I, 32'h678)},
                   {64'h108, imm_value(IMM_U, 32'hfffff) + imm_value(IMM_I, 32'hfff)},
                   {64'h110, RESET_PC + 64'd16 + imm_value(IMM_U, 32'h00010)},
                   {64'h118, imm_value(IMM_I, 32'h800)},
                   {64'h120, imm_value(IMM_U, 32'h80000)}};
    run_program();
    check_stores("upper_immediates");
    finish_test("upper_immediates");
  endtask

  task automatic store_offsets();
    logic [XLEN-1:0] data;
    data = imm_value(IMM_U, 32'habcde) + imm_value(IMM_I, 32'h123);
    // Reset has to mask the strobe of the sd sitting at the reset PC
    prog = '{sd_inst(5'd0, 5'd0, 12'h7f8), addi_inst(5'd10, 5'd0, 12'h400),
             lui_inst(5'd6, 20'habcde), addi_inst(5'd6, 5'd6, 12'h123),
             sd_inst(5'd6, 5'd10, 12'hfe8), sd_inst(5'd6, 5'd10, 12'h800),
             sd_inst(5'd6, 5'd10, 12'h7ff), ebreak_inst()};
    exp_stores = '{{imm_value(IMM_S, 32'h7f8), 64'd0},
                   {64'h400 + imm_value(IMM_S, 32'hfe8), data},
                   {64'h400 + imm_value(IMM_S, 32'h800), data},
                   {64'h400 + imm_value(IMM_S, 32'h7ff), data}};
    run_program();
    check_stores("store_offsets");
    finish_test("store_offsets");
  endtask

  task automatic jumps_and_links();
    // Jalr lands on x5 + 17 with bit 0 dropped, word 8, so any odd PC fetches ebreak
    prog = '{addi_inst(5'd10, 5'd0, 12'h200), jal_inst(5'd1, 21'd12),
             sd_inst(5'd0, 5'd10, 12'h000), sd_inst(5'd0, 5'd10, 12'h008),
             auipc_inst(5'd5, 20'h00000), jalr_inst(5'd2, 5'd5, 12'd17),
             sd_inst(5'd0, 5'd10, 12'h010), sd_inst(5'd0, 5'd10, 12'h018),
             sd_inst(5'd1, 5'd10, 12'h020), sd_inst(5'd2, 5'd10, 12'h028),
             jal_inst(5'd3, 21'd8), sd_inst(5'd0, 5'd10, 12'h038),
             sd_inst(5'd3, 5'd10, 12'h030), ebreak_inst()};
    exp_stores = '{{64'h220, RESET_PC + 64'd8},
                   {64'h228, RESET_PC + 64'd24},
                   {64'h230, RESET_PC + 64'd44}};
    run_program();
    if (pc !== RESET_PC + 64'd52) mismatch("pc at final ebreak", pc, RESET_PC + 64'd52);
    check_stores("jumps_and_links");
    finish_test("jumps_and_links");
  endtask

  task automatic halt_freeze();
    prog = '{addi_inst(5'd10, 5'd0, 12'h300), addi_inst(5'd1, 5'd0, 12'h005),
             sd_inst(5'd1, 5'd10, 12'h000), ebreak_inst(),
             sd_inst(5'd1, 5'd10, 12'h008), sd_inst(5'd1, 5'd10, 12'h010)};
    exp_stores = '{{64'h300, imm_value(IMM_I, 32'h005)}};
    run_program();
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      if (halt !== 1'b1) mismatch("halt while frozen", {63'd0, halt}, 64'd1);
      if (pc !== RESET_PC + 64'd12) mismatch("pc while frozen", pc, RESET_PC + 64'd12);
      if (mem_wen !== 1'b0) mismatch("mem_wen while frozen", {63'd0, mem_wen}, 64'd0);
    end
    check_stores("halt_freeze");
    finish_test("halt_freeze");
  endtask

  task automatic random_addi();
    logic [31:0]     rnd;
    logic [11:0]     imm;
    logic [XLEN-1:0] acc;
    acc = '0;
    prog.delete();
    exp_stores.delete();
    prog.push_back(addi_inst(5'd10, 5'd0, 12'h500));
    for (int k = 0; k < 20; k++) begin
      rnd = lcg_next();
      imm = rnd[27:16];
      prog.push_back(addi_inst(5'd1, (k == 0) ? 5'd0 : 5'd1, imm));
      prog.push_back(sd_inst(5'd1, 5'd10, 12'(8 * k)));
      acc = acc + imm_value(IMM_I, {20'd0, imm});
      exp_stores.push_back({64'h500 + 64'(8 * k), acc});
    end
    prog.push_back(addi_inst(5'd0, 5'd1, 12'h07b));
    prog.push_back(sd_inst(5'd0, 5'd10, 12'h0a0));
    prog.push_back(ebreak_inst());
    exp_stores.push_back({64'h5a0, 64'd0});
    run_program();
    check_stores("random_addi");
    finish_test("random_addi");
  endtask

  initial begin
    for (int t = 0; t < 6 && !timed_out; t++) begin
      case (t)
        0:       reset_and_halt();
        1:       upper_immediates();
        2:       store_offsets();
        3:       jumps_and_links();
        4:       halt_freeze();
        default: random_addi();
      endcase
    end
    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== rv64_core.f ====
src/rv_isa_pkg.sv
src/core_ctrl_pkg.sv
src/mux_key.sv
src/idu.sv
src/regfile.sv
src/exu.sv
src/rv64_core.sv
test/tb_core.sv

// ==== Makefile ====
TB_TOP := tb_core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module rv64_core -f rv64_core.f

sim:
	verilator --binary --timing --top-module $(TB_TOP) -f rv64_core.f -o sim_core
	@out="$$(./obj_dir/sim_core)"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
